//--- verilog.f
rtl/fetch_pkg.sv
rtl/rvc_expander.sv
rtl/static_predictor.sv
rtl/fetch_sequencer.sv
rtl/fetch_stage.sv
verif/fetch_stage_props.sv
verif/fetch_stage_tb.sv

//--- Bender.yml
package:
  name: fetch_stage

dependencies: {}

sources:
  # Design
  - rtl/fetch_pkg.sv
  - rtl/rvc_expander.sv
  - rtl/static_predictor.sv
  - rtl/fetch_sequencer.sv
  - rtl/fetch_stage.sv

  # Verification
  - target: simulation
    files:
      - verif/fetch_stage_props.sv
      - verif/fetch_stage_tb.sv

//--- verif/fetch_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage_tb;

    localparam int              PC_W     = 18;
    localparam int              MAX_ROWS = 32;
    localparam int              WAIT_MAX = 20;           // Cycles allowed for ready_o
    localparam logic [31:0]     EBREAK   = 32'h0010_0073;
    localparam logic [PC_W-1:0] END_ADDR = 'h4C;         // PC after the last row

    logic            clk_i;
    logic            rst_i;
    logic [31:0]     mem_data_i;
    logic            mem_wait_i;
    logic [PC_W-1:0] mem_addr_o;
    logic            stall_i;
    logic            flush_i;
    logic            ready_o;
    logic            redirect_valid_i;
    logic [PC_W-1:0] redirect_pc_i;
    logic [31:0]     instr_o;
    logic [PC_W-1:0] pc_o;
    logic [PC_W-1:0] pc_link_o;

    // Stimulus and expected values, one entry per row
    logic [31:0]     t_data  [MAX_ROWS];
    logic            t_stall [MAX_ROWS];
    logic            t_flush [MAX_ROWS];
    logic            t_redir [MAX_ROWS];
    logic [PC_W-1:0] t_rpc   [MAX_ROWS];
    logic [PC_W-1:0] t_addr  [MAX_ROWS];  // mem_addr_o before the edge
    logic [31:0]     t_instr [MAX_ROWS];  // Decode outputs after the edge
    logic [PC_W-1:0] t_pc    [MAX_ROWS];
    logic [PC_W-1:0] t_link  [MAX_ROWS];

    int n_rows = 0;
    int tests  = 0;
    int checks = 0;
    int errors = 0;

    fetch_stage #(
        .PC_W (PC_W)
    ) UUT (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .mem_data_i       (mem_data_i),
        .mem_wait_i       (mem_wait_i),
        .mem_addr_o       (mem_addr_o),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .ready_o          (ready_o),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .instr_o          (instr_o),
        .pc_o             (pc_o),
        .pc_link_o        (pc_link_o)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "FAIL");
    endtask

    task automatic add_row(input logic [31:0] data, input logic stall, input logic flush,
                           input logic redir, input logic [PC_W-1:0] rpc,
                           input logic [PC_W-1:0] addr, input logic [31:0] instr,
                           input logic [PC_W-1:0] pc, input logic [PC_W-1:0] link);
        t_data[n_rows]  = data;
        t_stall[n_rows] = stall;
        t_flush[n_rows] = flush;
        t_redir[n_rows] = redir;
        t_rpc[n_rows]   = rpc;
        t_addr[n_rows]  = addr;
        t_instr[n_rows] = instr;
        t_pc[n_rows]    = pc;
        t_link[n_rows]  = link;
        n_rows++;
    endtask

    task automatic build_table();
        //      data          st fl rd rpc    addr   instr          pc     link
        add_row(32'h0050_0093, 0, 0, 0, 'h00, 'h00, 32'h0050_0093, 'h00, 'h02); // addi
        add_row(32'h0000_040D, 0, 0, 0, 'h00, 'h02, 32'h0034_0413, 'h02, 'h03); // c.addi
        add_row(32'h0000_4144, 0, 0, 0, 'h00, 'h03, 32'h0045_2483, 'h03, 'h04); // c.lw
        add_row(32'h0000_C416, 0, 0, 0, 'h00, 'h04, 32'h0051_2423, 'h04, 'h05); // c.swsp
        add_row(32'h0000_8C05, 0, 0, 0, 'h00, 'h05, 32'h4094_0433, 'h05, 'h06); // c.sub
        add_row(32'h0000_8489, 0, 0, 0, 'h00, 'h06, 32'h4024_D493, 'h06, 'h07); // c.srai
        add_row(32'h0000_952E, 0, 0, 0, 'h00, 'h07, 32'h00B5_0533, 'h07, 'h08); // c.add
        add_row(32'h0000_8636, 0, 0, 0, 'h00, 'h08, 32'h00D0_0633, 'h08, 'h09); // c.mv
        add_row(32'h0000_8082, 0, 0, 0, 'h00, 'h09, 32'h0000_8067, 'h09, 'h0A); // c.jr
        add_row(32'h0100_006F, 0, 0, 0, 'h00, 'h0A, 32'h0100_006F, 'h0A, 'h0C); // jal +8
        add_row(32'h0000_BFF5, 0, 0, 0, 'h00, 'h12, 32'hFFDF_F06F, 'h12, 'h13); // c.j -2
        add_row(32'hFE20_8CE3, 0, 0, 0, 'h00, 'h10, 32'hFE20_8CE3, 'h10, 'h12); // beq back
        add_row(32'h0020_9463, 0, 0, 0, 'h00, 'h0C, 32'h0020_9463, 'h0C, 'h0E); // bne fwd
        add_row(32'h0100_006F, 0, 0, 1, 'h40, 'h0E, 32'h0100_006F, 'h0E, 'h10); // redirect
        add_row(32'h0050_0093, 0, 1, 0, 'h00, 'h40, EBREAK,        'h40, 'h42); // flush
        add_row(32'h0000_040D, 1, 0, 0, 'h00, 'h42, EBREAK,        'h40, 'h42); // stalled
        add_row(32'h0000_52FD, 0, 0, 0, 'h00, 'h42, 32'hFFF0_0293, 'h42, 'h43); // c.li
        add_row(32'h0000_2021, 0, 0, 0, 'h00, 'h43, 32'h0080_00EF, 'h43, 'h44); // c.jal
        add_row(32'h0000_0000, 0, 0, 0, 'h00, 'h47, EBREAK,        'h47, 'h48); // illegal
        add_row(32'h0000_0013, 0, 0, 0, 'h00, 'h48, 32'h0000_0013, 'h48, 'h4A);
        add_row(32'h0000_0013, 0, 0, 0, 'h00, 'h4A, 32'h0000_0013, 'h4A, 'h4C);
    endtask

    // Polls ready_o at falling edges, gives up after WAIT_MAX cycles
    task automatic wait_ready(output logic ok);
        int cnt;
        cnt = 0;
        while (ready_o !== 1'b1 && cnt < WAIT_MAX) begin
            @(negedge clk_i);
            cnt++;
        end
        ok = (ready_o === 1'b1);
        if (!ok) begin
            $display("timeout: ready_o stayed low for %0d cycles", WAIT_MAX);
        end
    endtask

    task automatic check_decode(input int row);
        check_value("instr_o", instr_o, t_instr[row]);
        check_value("pc_o", pc_o, t_pc[row]);
        check_value("pc_link_o", pc_link_o, t_link[row]);
    endtask

    initial begin
        logic [31:0]     seed;
        logic [PC_W-1:0] next_addr;
        logic            ok;
        logic            timed_out;
        int              row_err;
        int              hold;

        seed             = 32'he91a;
        timed_out        = 1'b0;
        clk_i            = 1'b0;
        rst_i            = 1'b1;
        mem_data_i       = '0;
        mem_wait_i       = 1'b0;
        stall_i          = 1'b1; // Nothing moves until the first row
        flush_i          = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        build_table();

        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        row_err = errors;
        check_value("mem_addr_o", mem_addr_o, 0);
        check_value("pc_o", pc_o, 0);
        check_value("pc_link_o", pc_link_o, 0);
        check_value("instr_o", instr_o, EBREAK);
        check_value("ready_o", ready_o, 1);
        @(posedge clk_i);
        mem_wait_i <= 1'b1;
        @(negedge clk_i);
        check_value("ready_o", ready_o, 0);
        @(posedge clk_i);
        mem_wait_i <= 1'b0;
        wait_ready(ok);
        timed_out = !ok;
        report_test("reset", row_err);

        for (int i = 0; i < n_rows && !timed_out; i++) begin
            row_err   = errors;
            next_addr = (i + 1 < n_rows) ? t_addr[i+1] : END_ADDR;
            @(posedge clk_i);
            mem_data_i       <= t_data[i];
            stall_i          <= t_stall[i];
            mem_wait_i       <= t_stall[i];  // Stalled row models a slow memory
            flush_i          <= t_flush[i];
            redirect_valid_i <= t_redir[i];
            redirect_pc_i    <= t_rpc[i];
            @(negedge clk_i);
            check_value("mem_addr_o", mem_addr_o, t_addr[i]);
            check_value("ready_o", ready_o, !t_stall[i]);

            @(posedge clk_i); // Capture edge
            seed = lcg_next(seed);
            mem_data_i       <= seed;
            stall_i          <= 1'b1;
            mem_wait_i       <= 1'b1;
            flush_i          <= 1'b0;
            redirect_valid_i <= 1'b0;
            redirect_pc_i    <= seed[PC_W-1:0];
            @(negedge clk_i);
            check_decode(i);
            check_value("mem_addr_o", mem_addr_o, next_addr);

            // Random stall stretch, garbage on the memory bus
            hold = (int'(seed[23:16]) % 3) + 1;
            for (int k = 0; k < hold; k++) begin
                @(posedge clk_i);
                seed = lcg_next(seed);
                mem_data_i <= seed;
                if (k == hold - 1) begin
                    mem_wait_i <= 1'b0;
                end
                @(negedge clk_i);
                check_decode(i);
                check_value("mem_addr_o", mem_addr_o, next_addr);
                check_value("ready_o", ready_o, (k == hold - 1));
            end
            wait_ready(ok);
            timed_out = !ok;
            report_test($sformatf("row %0d", i), row_err);
        end

        $display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests, checks, errors, UUT.u_fetch_stage_props.assert_failures);
        if (errors == 0 && !timed_out && UUT.u_fetch_stage_props.assert_failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/fetch_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage_props #(
    parameter int PC_W = fetch_pkg::PC_W_DEF
) (
    input logic                          clk_i,
    input logic                          rst_i,
    input logic [PC_W-1:0]               mem_addr_o,
    input logic                          stall_i,
    input logic                          flush_i,
    input logic [fetch_pkg::INSTR_W-1:0] instr_o,
    input logic [PC_W-1:0]               pc_o,
    input logic [PC_W-1:0]               pc_link_o
);
    import fetch_pkg::*;

    int assert_failures = 0; // Summed into the end-of-run verdict

    // Known state one cycle after reset
    reset_values: assert property (@(posedge clk_i)
        rst_i |=> (mem_addr_o == '0) && (pc_o == '0) && (pc_link_o == '0) &&
                  (instr_o == BUBBLE_INSTR))
        else begin
            $error("fetch state not cleared by reset");
            assert_failures++;
        end

    // Back-pressure, every register holds
    stall_hold: assert property (@(posedge clk_i)
        (stall_i && !rst_i) |=> $stable(mem_addr_o) && $stable(pc_o) &&
                                $stable(pc_link_o) && $stable(instr_o))
        else begin
            $error("fetch outputs moved under stall");
            assert_failures++;
        end

    flush_bubble: assert property (@(posedge clk_i)
        (flush_i && !stall_i && !rst_i) |=> (instr_o == BUBBLE_INSTR))
        else begin
            $error("flush did not insert a bubble");
            assert_failures++;
        end

endmodule

bind fetch_stage fetch_stage_props #(
    .PC_W (PC_W)
) u_fetch_stage_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .mem_addr_o (mem_addr_o),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .instr_o    (instr_o),
    .pc_o       (pc_o),
    .pc_link_o  (pc_link_o)
);

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter int PC_W = fetch_pkg::PC_W_DEF
) (
    input  logic                          clk_i,
    input  logic                          rst_i,

    // Instruction memory
    input  logic [fetch_pkg::INSTR_W-1:0] mem_data_i,
    input  logic                          mem_wait_i,
    output logic [PC_W-1:0]               mem_addr_o,

    // Pipeline controller
    input  logic                          stall_i,
    input  logic                          flush_i,
    output logic                          ready_o,

    // Execute
    input  logic                          redirect_valid_i,
    input  logic [PC_W-1:0]               redirect_pc_i,

    // Decode
    output logic [fetch_pkg::INSTR_W-1:0] instr_o,
    output logic [PC_W-1:0]               pc_o,
    output logic [PC_W-1:0]               pc_link_o
);
    import fetch_pkg::*;

    logic               is_compressed;
    logic [INSTR_W-1:0] expanded;
    logic [INSTR_W-1:0] instr_sel;  // What decode will see
    logic               taken;
    logic [PC_W-1:0]    target;

    assign is_compressed = (mem_data_i[1:0] != 2'b11);
    assign instr_sel     = is_compressed ? expanded : mem_data_i;
    assign ready_o       = ~mem_wait_i;

    rvc_expander u_rvc_expander (
        .rvc_i      (mem_data_i[15:0]),
        .expanded_o (expanded)
    );

    static_predictor #(
        .PC_W (PC_W)
    ) u_static_predictor (
        .instr_i  (instr_sel),
        .pc_i     (mem_addr_o),
        .taken_o  (taken),
        .target_o (target)
    );

    fetch_sequencer #(
        .PC_W (PC_W)
    ) u_fetch_sequencer (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .taken_i          (taken),
        .target_i         (target),
        .is_compressed_i  (is_compressed),
        .instr_i          (instr_sel),
        .fetch_pc_o       (mem_addr_o),  // Address goes out straight from the PC
        .pc_o             (pc_o),
        .instr_o          (instr_o),
        .pc_link_o        (pc_link_o)
    );

endmodule

`default_nettype wire

//--- rtl/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
    parameter int PC_W = fetch_pkg::PC_W_DEF
) (
    input  logic                          clk_i,
    input  logic                          rst_i,

    // Pipeline control
    input  logic                          stall_i,
    input  logic                          flush_i,

    // Execute correction
    input  logic                          redirect_valid_i,
    input  logic [PC_W-1:0]               redirect_pc_i,

    // Current fetch
    input  logic                          taken_i,
    input  logic [PC_W-1:0]               target_i,
    input  logic                          is_compressed_i,
    input  logic [fetch_pkg::INSTR_W-1:0] instr_i,
    output logic [PC_W-1:0]               fetch_pc_o,

    // Toward decode
    output logic [PC_W-1:0]               pc_o,
    output logic [fetch_pkg::INSTR_W-1:0] instr_o,
    output logic [PC_W-1:0]               pc_link_o
);
    import fetch_pkg::*;

    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_seq;
    logic [PC_W-1:0] pc_next;

    // One halfword for RVC, two otherwise
    assign pc_seq = pc_q + (is_compressed_i ? PC_W'(1) : PC_W'(2));

    always_comb begin
        if (redirect_valid_i) begin
            pc_next = redirect_pc_i; // Execute knows better than the guess
        end else if (taken_i) begin
            pc_next = target_i;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q      <= '0;
            pc_o      <= '0;
            pc_link_o <= '0;
            instr_o   <= BUBBLE_INSTR;
        end else if (!stall_i) begin
            pc_q      <= pc_next;  // PC keeps moving even on flush
            pc_o      <= pc_q;
            pc_link_o <= pc_seq;
            instr_o   <= flush_i ? BUBBLE_INSTR : instr_i;
        end
    end

    assign fetch_pc_o = pc_q;

endmodule

`default_nettype wire

//--- rtl/static_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module static_predictor #(
    parameter int PC_W = fetch_pkg::PC_W_DEF
) (
    input  logic [fetch_pkg::INSTR_W-1:0] instr_i,
    input  logic [PC_W-1:0]               pc_i,
    output logic                          taken_o,
    output logic [PC_W-1:0]               target_o
);
    import fetch_pkg::*;

    opcode_e            opcode;
    imm_fmt_e           imm_fmt;
    logic [INSTR_W-1:0] imm_bytes; // Sign-extended byte offset
    logic [PC_W-1:0]    imm_hw;    // Same offset in halfwords

    assign opcode = to_opcode(instr_i[6:2]);

    always_comb begin
        case (opcode)
            JAL:     imm_fmt = IMM_J;
            BRANCH:  imm_fmt = IMM_B;
            default: imm_fmt = IMM_I; // JALR lands here, target needs rs1
        endcase
    end

    always_comb begin
        case (imm_fmt)
            IMM_J: begin
                imm_bytes = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                             instr_i[30:21], 1'b0};
            end
            IMM_B: begin
                imm_bytes = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                             instr_i[11:8], 1'b0};
            end
            default: begin
                imm_bytes = {{21{instr_i[31]}}, instr_i[30:20]};
            end
        endcase
    end

    // Byte bit 0 is always zero for control transfers
    assign imm_hw = imm_bytes[PC_W:1];

    // Backward branches are usually loops
    assign taken_o = (opcode == JAL) ||
                     ((opcode == BRANCH) && imm_bytes[INSTR_W-1]);

    assign target_o = pc_i + imm_hw;

endmodule

`default_nettype wire

//--- rtl/rvc_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
    input  logic [15:0]                   rvc_i,
    output logic [fetch_pkg::INSTR_W-1:0] expanded_o
);
    import fetch_pkg::*;

    // 7-bit major opcodes of the expanded forms
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = {BRANCH, 2'b11};
    localparam logic [6:0] OPC_JALR   = {JALR, 2'b11};
    localparam logic [6:0] OPC_JAL    = {JAL, 2'b11};

    logic [4:0]  rd;        // Full 5-bit register fields
    logic [4:0]  rs2;
    logic [4:0]  rs1_p;     // x8..x15 from bits 9..7
    logic [4:0]  rs2_p;     // x8..x15 from bits 4..2
    logic [11:0] imm6_sx;   // CI immediate, sign-extended to 12 bits
    logic [19:0] jal_imm;   // Already in JAL bit order
    logic [2:0]  ca_funct3;

    assign rd      = rvc_i[11:7];
    assign rs2     = rvc_i[6:2];
    assign rs1_p   = {2'b01, rvc_i[9:7]};
    assign rs2_p   = {2'b01, rvc_i[4:2]};
    assign imm6_sx = {{7{rvc_i[12]}}, rvc_i[6:2]};

    // {imm[20], imm[10:1], imm[11], imm[19:12]}
    assign jal_imm = {rvc_i[12], rvc_i[8], rvc_i[10:9], rvc_i[6], rvc_i[7],
                      rvc_i[2], rvc_i[11], rvc_i[5:3], rvc_i[12], {8{rvc_i[12]}}};

    // C.SUB / C.XOR / C.OR / C.AND
    always_comb begin
        case (rvc_i[6:5])
            2'b00:   ca_funct3 = 3'b000;
            2'b01:   ca_funct3 = 3'b100;
            2'b10:   ca_funct3 = 3'b110;
            default: ca_funct3 = 3'b111;
        endcase
    end

    always_comb begin
        expanded_o = BUBBLE_INSTR; // Reserved or unsupported encodings
        case ({rvc_i[15:13], rvc_i[1:0]})
            5'b000_00: begin // C.ADDI4SPN
                if (rvc_i[12:5] != 8'd0) begin
                    expanded_o = {2'b00, rvc_i[10:7], rvc_i[12:11], rvc_i[5], rvc_i[6],
                                  2'b00, 5'd2, 3'b000, rs2_p, OPC_OP_IMM};
                end
            end
            5'b010_00: begin // C.LW
                expanded_o = {5'b0, rvc_i[5], rvc_i[12:10], rvc_i[6], 2'b00,
                              rs1_p, 3'b010, rs2_p, OPC_LOAD};
            end
            5'b110_00: begin // C.SW
                expanded_o = {5'b0, rvc_i[5], rvc_i[12], rs2_p, rs1_p, 3'b010,
                              rvc_i[11:10], rvc_i[6], 2'b00, OPC_STORE};
            end
            5'b000_01: expanded_o = {imm6_sx, rd, 3'b000, rd, OPC_OP_IMM}; // C.ADDI, C.NOP
            5'b001_01: expanded_o = {jal_imm, 5'd1, OPC_JAL};              // C.JAL, links x1
            5'b010_01: expanded_o = {imm6_sx, 5'd0, 3'b000, rd, OPC_OP_IMM}; // C.LI
            5'b011_01: begin
                if (rd == 5'd2) begin
                    // C.ADDI16SP, immediate in units of 16 bytes
                    if ({rvc_i[12], rvc_i[6:2]} != 6'd0) begin
                        expanded_o = {{3{rvc_i[12]}}, rvc_i[4:3], rvc_i[5], rvc_i[2],
                                      rvc_i[6], 4'b0000, 5'd2, 3'b000, 5'd2, OPC_OP_IMM};
                    end
                end else if ({rvc_i[12], rvc_i[6:2]} != 6'd0) begin
                    expanded_o = {{15{rvc_i[12]}}, rvc_i[6:2], rd, OPC_LUI}; // C.LUI
                end
            end
            5'b100_01: begin
                case (rvc_i[11:10])
                    2'b00, 2'b01: begin // C.SRLI / C.SRAI, bit 10 picks arithmetic
                        if (!rvc_i[12]) begin
                            expanded_o = {1'b0, rvc_i[10], 5'b0, rvc_i[6:2], rs1_p,
                                          3'b101, rs1_p, OPC_OP_IMM};
                        end
                    end
                    2'b10: expanded_o = {imm6_sx, rs1_p, 3'b111, rs1_p, OPC_OP_IMM}; // C.ANDI
                    default: begin
                        // Bit 12 set selects RV64-only forms
                        if (!rvc_i[12]) begin
                            expanded_o = {1'b0, (rvc_i[6:5] == 2'b00), 5'b0, rs2_p, rs1_p,
                                          ca_funct3, rs1_p, OPC_OP};
                        end
                    end
                endcase
            end
            5'b101_01: expanded_o = {jal_imm, 5'd0, OPC_JAL}; // C.J
            5'b110_01, 5'b111_01: begin
                // C.BEQZ / C.BNEZ, bit 13 becomes funct3[0]
                expanded_o = {rvc_i[12], {3{rvc_i[12]}}, rvc_i[6:5], rvc_i[2], 5'd0, rs1_p,
                              2'b00, rvc_i[13], rvc_i[11:10], rvc_i[4:3], rvc_i[12],
                              OPC_BRANCH};
            end
            5'b000_10: begin // C.SLLI
                if (!rvc_i[12]) begin
                    expanded_o = {7'b0, rvc_i[6:2], rd, 3'b001, rd, OPC_OP_IMM};
                end
            end
            5'b010_10: begin // C.LWSP
                if (rd != 5'd0) begin
                    expanded_o = {4'b0, rvc_i[3:2], rvc_i[12], rvc_i[6:4], 2'b00,
                                  5'd2, 3'b010, rd, OPC_LOAD};
                end
            end
            5'b100_10: begin
                if (!rvc_i[12]) begin
                    if (rs2 == 5'd0) begin
                        if (rd != 5'd0) begin
                            expanded_o = {12'b0, rd, 3'b000, 5'd0, OPC_JALR}; // C.JR
                        end
                    end else begin
                        expanded_o = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP}; // C.MV
                    end
                end else if (rs2 == 5'd0) begin
                    if (rd == 5'd0) begin
                        expanded_o = BUBBLE_INSTR; // C.EBREAK, same word
                    end else begin
                        expanded_o = {12'b0, rd, 3'b000, 5'd1, OPC_JALR}; // C.JALR
                    end
                end else begin
                    expanded_o = {7'b0, rs2, rd, 3'b000, rd, OPC_OP}; // C.ADD
                end
            end
            5'b110_10: begin // C.SWSP
                expanded_o = {4'b0, rvc_i[8:7], rvc_i[12], rs2, 5'd2, 3'b010,
                              rvc_i[11:9], 2'b00, OPC_STORE};
            end
            default: expanded_o = BUBBLE_INSTR;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // PC counts halfwords, byte address bit 0 is implied
    localparam int PC_W_DEF = 18;
    localparam int INSTR_W  = 32;

    // EBREAK, safe filler for decode (all-zero would decode as a load)
    localparam logic [INSTR_W-1:0] BUBBLE_INSTR = 32'h0010_0073;

    // Major opcode, instruction bits 6..2
    typedef enum logic [4:0] {
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011,
        OTHER  = 5'b11111  // Everything without a control-flow effect here
    } opcode_e;

    // Immediate layouts the predictor has to unpack
    typedef enum logic [1:0] {
        IMM_I,
        IMM_B,
        IMM_J
    } imm_fmt_e;

    // Raw opcode bits to enum, unknown codes fold into OTHER
    function automatic opcode_e to_opcode(input logic [4:0] op_bits);
        opcode_e op;
        case (op_bits)
            5'b11000: op = BRANCH;
            5'b11001: op = JALR;
            5'b11011: op = JAL;
            default:  op = OTHER;
        endcase
        return op;
    endfunction

endpackage

`default_nettype wire
